// File: Makefile
# Verilator build and run of the processor testbench

BUILD := obj_dir

.PHONY: all run clean

all: $(BUILD)/VProcessorTb

$(BUILD)/VProcessorTb: tb.f verilog/Processor_settings.svh verilog/Types.sv \
		verilog/CoreBuses.sv verilog/InstL1Cache.sv verilog/RegisterFile.sv \
		verilog/Alu.sv verilog/CoreSC.sv verilog/Processor.sv testbench/ProcessorTb.sv
	verilator --binary --timing --top-module ProcessorTb -Mdir $(BUILD) -f tb.f

run: $(BUILD)/VProcessorTb
	$(BUILD)/VProcessorTb > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf $(BUILD) sim.log

// File: tb.f
+incdir+verilog
verilog/Types.sv
verilog/CoreBuses.sv
verilog/InstL1Cache.sv
verilog/RegisterFile.sv
verilog/Alu.sv
verilog/CoreSC.sv
verilog/Processor.sv
testbench/ProcessorTb.sv

// File: testbench/ProcessorTb.sv
/*
 * Testbench for the processor subsystem. Runs a fixed program from modelled
 * memories with random wait states on both buses and checks every store and
 * the external fetch count against an ISA-level model of the same program.
 */

`include "Processor_settings.svh"

module ProcessorTb;

    localparam int ResetCycles = 16;
    localparam int DrainCycles = 64;           // Quiet time after the last store
    localparam int MemWords    = 256;          // Size of both memory models
    localparam int OpImm       = 'h13;         // Major opcodes for the encoders
    localparam int OpLoad      = 'h03;

    logic       i_clock;
    logic       i_reset;
    Types::Addr o_instAddr;
    logic       o_instRe;
    Types::Inst i_inst;
    logic       i_instBusy;
    Types::Addr o_dataAddr;
    logic       o_dataWe;
    logic       o_dataRe;
    Types::Word o_dataWdata;
    Types::Word i_dataRdata;
    logic       i_dataBusy;

    Types::Inst imem[MemWords];
    Types::Word dmem[MemWords];
    Types::Word refMem[MemWords];              // Data memory of the ISA model
    int         progIndex;

    Types::Addr expAddr[$];                    // Expected stores, in order
    Types::Word expData[$];
    int         expLines;                      // Distinct lines up to last store
    int         expFetches;                    // Instructions up to last store
    int         expLoads;                      // Loads of the whole program

    int         seed;
    int         instWait, dataWait;            // Wait states left
    logic       instActive, dataActive;
    logic       instDone, dataDone;            // Transfer ends at next edge

    int         errors, storeCount, instReads, lastStoreReads, loadCount;
    logic       fetchSeen;

    Processor Processor_i (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .o_instAddr  (o_instAddr),
        .o_instRe    (o_instRe),
        .i_inst      (i_inst),
        .i_instBusy  (i_instBusy),
        .o_dataAddr  (o_dataAddr),
        .o_dataWe    (o_dataWe),
        .o_dataRe    (o_dataRe),
        .o_dataWdata (o_dataWdata),
        .i_dataRdata (i_dataRdata),
        .i_dataBusy  (i_dataBusy));

    initial begin
        i_clock = 1'b0;
        forever #2 i_clock = ~i_clock;
    end

    // ------------------------------------------------------------------------
    // RV32I instruction encoders
    // ------------------------------------------------------------------------

    function automatic Types::Inst encR(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic Types::Inst encI(int op, int imm, int rs1, int f3, int rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic Types::Inst encS(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic Types::Inst encB(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0],
                imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic Types::Inst encU(int imm20, int rd);    // LUI
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic Types::Inst encJ(int imm, int rd);      // JAL
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic appendInst(input Types::Inst ins);
        imem[progIndex] = ins;
        progIndex++;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < MemWords; i++)
            imem[i] = encI(OpImm, i, 0, 0, 0);     // NOP with the word index as imm
        progIndex = `RV_RESET_PC >> 2;
        appendInst(encU('h12345, 1));              // 0  x1 = 0x12345000
        appendInst(encI(OpImm, 'h678, 1, 0, 1));   // 1  x1 = 0x12345678
        appendInst(encI(OpImm, 'h200, 0, 0, 2));   // 2  x2 = data base
        appendInst(encS(0, 1, 2));
        appendInst(encI(OpImm, -5, 0, 0, 3));      // 4  x3 = -5
        appendInst(encR(0, 3, 1, 0, 4));           // 5  add
        appendInst(encS(4, 4, 2));
        appendInst(encR('h20, 3, 1, 0, 5));        // 7  sub
        appendInst(encS(8, 5, 2));
        appendInst(encR(0, 3, 1, 7, 6));           // 9  and
        appendInst(encR(0, 3, 1, 6, 7));           // 10 or
        appendInst(encR(0, 7, 6, 4, 8));           // 11 xor of both
        appendInst(encS(12, 8, 2));
        appendInst(encI(OpLoad, 64, 2, 2, 9));     // 13 lw from 0x240
        appendInst(encI(OpLoad, 68, 2, 2, 10));    // 14 lw from 0x244
        appendInst(encR(0, 10, 9, 0, 11));
        appendInst(encS(16, 11, 2));               // 16 loaded sum
        appendInst(encI(OpImm, 5, 0, 0, 12));      // 17 loop count
        appendInst(encI(OpImm, 0, 0, 0, 13));
        appendInst(encR(0, 12, 13, 0, 13));        // 19 loop body
        appendInst(encS(20, 13, 2));
        appendInst(encI(OpImm, -1, 12, 0, 12));
        appendInst(encB(-12, 0, 12, 1));           // 22 bne back to 19
        appendInst(encB(8, 0, 13, 0));             // 23 beq not taken
        appendInst(encS(24, 13, 2));
        appendInst(encB(8, 0, 12, 0));             // 25 beq taken
        appendInst(encS(28, 1, 2));                // Skipped
        appendInst(encJ(8, 14));                   // 27 jal with link in x14
        appendInst(encS(32, 1, 2));                // Skipped
        appendInst(encS(36, 14, 2));               // 29 last store holds the link
        appendInst(encJ(0, 0));                    // Halt loop
    endtask

    task automatic fillData();
        for (int i = 0; i < MemWords; i++)
            dmem[i] = 32'hC0DE_0000 ^ (i * 32'h0001_0203);
        dmem[144] = 32'h0F0F_1234;                 // Word at 0x240
        dmem[145] = 32'h7000_00C3;                 // Word at 0x244
    endtask

    // ------------------------------------------------------------------------
    // ISA-level model that fills the expected store list
    // ------------------------------------------------------------------------

    function automatic int runReference();
        Types::Word     regs[32];
        bit             lineSeen[int];
        Types::Addr     pc, nextPc, addr;
        Types::Inst     ins;
        Types::RegIndex rd;
        Types::Word     a, b, immI, immS, immB, immJ;
        int             count;
        regs   = '{default: '0};
        refMem = dmem;
        pc     = `RV_RESET_PC;
        count  = 0;
        while (count < 1000) begin
            ins = imem[pc[9:2]];
            if (ins == encJ(0, 0))
                break;                              // Halt reached
            count++;
            lineSeen[int'(pc / (`RV_ICACHE_LINE_WORDS * 4))] = 1'b1;
            rd     = ins[11:7];
            a      = regs[ins[19:15]];
            b      = regs[ins[24:20]];
            immI   = {{20{ins[31]}}, ins[31:20]};
            immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            immJ   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            nextPc = pc + 4;
            case (ins[6:0])
                7'b0110011:
                    case (ins[14:12])
                        3'd0:    regs[rd] = ins[30] ? a - b : a + b;
                        3'd4:    regs[rd] = a ^ b;
                        3'd6:    regs[rd] = a | b;
                        3'd7:    regs[rd] = a & b;
                        default: ;
                    endcase
                7'b0010011: regs[rd] = a + immI;         // ADDI
                7'b0110111: regs[rd] = {ins[31:12], 12'h000};
                7'b0000011: begin
                    addr     = a + immI;
                    regs[rd] = refMem[addr[9:2]];
                    expLoads++;
                end
                7'b0100011: begin
                    addr = a + immS;
                    refMem[addr[9:2]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                    expLines   = lineSeen.num();
                    expFetches = count;
                end
                7'b1100011:
                    if ((a == b) != ins[12])            // BEQ or BNE taken
                        nextPc = pc + immB;
                7'b1101111: begin
                    regs[rd] = pc + 4;
                    nextPc   = pc + immJ;
                end
                default: ;
            endcase
            regs[0] = '0;
            pc      = nextPc;
        end
        return count;
    endfunction

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------

    task automatic compareAddr(input string name, input Types::Addr expected,
                               input Types::Addr actual);
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic compareWord(input string name, input Types::Word expected,
                               input Types::Word actual);
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic compareCount(input string name, input int expected, input int actual);
        if (actual != expected) begin
            errors++;
            $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic checkStore();
        if (storeCount < expAddr.size()) begin
            compareAddr($sformatf("store %0d address", storeCount),
                        expAddr[storeCount], o_dataAddr);
            compareWord($sformatf("store %0d data", storeCount),
                        expData[storeCount], o_dataWdata);
        end
        else begin
            errors++;
            $display("extra store to %h with data %h", o_dataAddr, o_dataWdata);
        end
        dmem[o_dataAddr[9:2]] = o_dataWdata;
        storeCount++;
        if (storeCount == expAddr.size())
            lastStoreReads = instReads;             // Fetches up to the last store
    endtask

    function automatic int drawDelay();
        return $unsigned($random(seed)) % 4;        // 0 to 3 busy cycles
    endfunction

    // Bus models draw a new wait for each request
    always begin
        @(posedge i_clock);
        #1;
        if (o_instRe !== 1'b1) begin
            instActive = 1'b0;
            instWait   = 0;
        end
        else if (!instActive || instDone) begin
            instActive = 1'b1;
            instWait   = drawDelay();
        end
        else if (instWait > 0)
            instWait--;
        i_instBusy = instWait != 0;
        i_inst     = imem[o_instAddr[9:2]];
        #1;                                         // Data request settled
        if (o_dataRe !== 1'b1 && o_dataWe !== 1'b1) begin
            dataActive = 1'b0;
            dataWait   = 0;
        end
        else if (!dataActive || dataDone) begin
            dataActive = 1'b1;
            dataWait   = drawDelay();
        end
        else if (dataWait > 0)
            dataWait--;
        i_dataBusy  = dataWait != 0;
        i_dataRdata = dmem[o_dataAddr[9:2]];
    end

    // Monitor samples one unit before the next edge
    always begin
        @(posedge i_clock);
        #3;
        instDone = (o_instRe === 1'b1) && !i_instBusy;
        dataDone = (o_dataRe === 1'b1 || o_dataWe === 1'b1) && !i_dataBusy;
        if (i_reset && (o_dataWe !== 1'b0 || o_dataRe !== 1'b0)) begin
            errors++;
            $display("data bus request raised while reset is high");
        end
        if (o_instRe === 1'b1 && !fetchSeen) begin
            fetchSeen = 1'b1;
            compareAddr("first fetch address", `RV_RESET_PC, o_instAddr);
        end
        if (!i_reset && instDone)
            instReads++;
        if (!i_reset && dataDone && o_dataRe === 1'b1)
            loadCount++;
        if (!i_reset && dataDone && o_dataWe === 1'b1)
            checkStore();
    end

    initial begin
        int refCount;
        int limit;
        int cycles;
        seed           = 51718;
        i_reset        = 1'b1;
        i_inst         = '0;
        i_instBusy     = 1'b0;
        i_dataRdata    = '0;
        i_dataBusy     = 1'b0;
        errors         = 0;
        storeCount     = 0;
        instReads      = 0;
        lastStoreReads = 0;
        loadCount      = 0;
        expLoads       = 0;
        fetchSeen      = 1'b0;
        instWait       = 0;
        dataWait       = 0;
        instActive     = 1'b0;
        dataActive     = 1'b0;
        instDone       = 1'b0;
        dataDone       = 1'b0;
        loadProgram();
        fillData();
        refCount = runReference();
        limit    = 40 * refCount * 4 + ResetCycles; // Worst wait on every step
        cycles   = 0;
        repeat (ResetCycles) begin
            @(posedge i_clock);
            cycles++;
        end
        #1 i_reset = 1'b0;
        while (storeCount < expAddr.size() && cycles < limit) begin
            @(posedge i_clock);
            cycles++;
        end
        if (storeCount < expAddr.size()) begin
            errors++;
            $display("timeout after %0d cycles, %0d of %0d stores never seen",
                     cycles, expAddr.size() - storeCount, expAddr.size());
        end
        else begin
            repeat (DrainCycles) @(posedge i_clock);    // Halt loop stores nothing
            if (`RV_ICACHE_ON == 1)
                compareCount("external instruction reads",
                             expLines * `RV_ICACHE_LINE_WORDS, lastStoreReads);
            else
                compareCount("external instruction reads", expFetches, lastStoreReads);
            compareCount("completed loads", expLoads, loadCount);
        end
        $display("Errors: %0d, stores checked: %0d of %0d",
                 errors, storeCount, expAddr.size());
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: verilog/Alu.sv
/*
 * Integer ALU of the single-cycle core. The zero flag is used by the core
 * to resolve BEQ and BNE from a subtraction.
 */

module Alu (
    input  Types::AluOp i_op,     // Operation
    input  Types::Word  i_a,      // Operand A, rs1
    input  Types::Word  i_b,      // Operand B, rs2 or immediate
    output Types::Word  o_result, // Result
    output logic        o_zero);  // Result is zero

    always_comb begin
        case (i_op)
            Types::AluAdd:   o_result = i_a + i_b;
            Types::AluSub:   o_result = i_a - i_b;
            Types::AluAnd:   o_result = i_a & i_b;
            Types::AluOr:    o_result = i_a | i_b;
            Types::AluXor:   o_result = i_a ^ i_b;
            Types::AluPassB: o_result = i_b;      // LUI
            default:         o_result = '0;
        endcase
    end

    // Equal operands after SUB
    assign o_zero = o_result == '0;

endmodule

// File: verilog/CoreBuses.sv
/*
 * Core-side bus interfaces. Request and address are held by the master
 * until a cycle with busy low; read data is valid in that cycle.
 */

// ------------------------------------------------------------------------
// Instruction bus
// ------------------------------------------------------------------------

interface InstCoreBus;

    Types::Addr addr; // Fetch address
    logic       re;   // Read request
    Types::Inst inst; // Fetched word
    logic       busy; // Slave not ready

    modport master (output addr, re, input inst, busy);
    modport slave  (input addr, re, output inst, busy);

endinterface

// ------------------------------------------------------------------------
// Data bus, word access only
// ------------------------------------------------------------------------

interface DataCoreBus;

    Types::Addr addr;  // Byte address
    logic       we;    // Write request
    logic       re;    // Read request
    Types::Word wdata; // Store data
    Types::Word rdata; // Load data
    logic       busy;  // Slave not ready

    modport master (output addr, we, re, wdata, input rdata, busy);
    modport slave  (input addr, we, re, wdata, output rdata, busy);

endinterface

// File: verilog/CoreSC.sv
/*
 * Single-cycle RV32I subset core. Fetch, decode, execute, memory access
 * and write-back in one cycle; busy on either bus stalls the whole core.
 */

`include "Processor_settings.svh"

module CoreSC (
    input  logic       i_clock,  // Clock
    input  logic       i_reset,  // Reset
    InstCoreBus.master instBus,  // Instruction fetch
    DataCoreBus.master dataBus); // Loads and stores

    // Major opcodes of the subset
    localparam logic [6:0] OpReg    = 7'b0110011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJal    = 7'b1101111;

    // Write-back source
    localparam logic [1:0] WbAlu  = 2'd0;
    localparam logic [1:0] WbMem  = 2'd1;
    localparam logic [1:0] WbLink = 2'd2;

    Types::Addr     pc;
    Types::Inst     instHeld;      // Fetched word waiting for data bus
    logic           instHeldValid;
    Types::Inst     inst;          // Instruction being executed
    logic           haveInst;
    logic           retire;

    // Decode fields
    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic           subFlag;       // funct7 bit 5
    Types::RegIndex rs1, rs2, rd;
    Types::Word     immI, immS, immB, immU, immJ, imm;

    // Control
    logic           regWrite, aluSrcImm, memRead, memWrite;
    logic           branch, branchNe, jump, branchTaken;
    logic [1:0]     wbSel;
    Types::AluOp    aluOp;

    // Datapath
    Types::Word     rs1Data, rs2Data, aluB, aluResult, wbData;
    logic           aluZero;
    Types::Addr     pcPlus4, pcNext;

    // ----------------------------------------------------------------------
    // Fetch and stall control
    // ----------------------------------------------------------------------

    assign instBus.addr = pc;
    assign instBus.re   = !instHeldValid;             // Refetch not needed
    assign inst         = instHeldValid ? instHeld : instBus.inst;
    assign haveInst     = instHeldValid || !instBus.busy;
    assign retire       = haveInst && (!(memRead || memWrite) || !dataBus.busy);

    // ----------------------------------------------------------------------
    // Decode
    // ----------------------------------------------------------------------

    assign opcode  = inst[6:0];
    assign rd      = inst[11:7];
    assign funct3  = inst[14:12];
    assign rs1     = inst[19:15];
    assign rs2     = inst[24:20];
    assign subFlag = inst[30];

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {inst[31:12], 12'b0};
    assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        regWrite  = 1'b0;            // Unknown opcodes act as NOP
        aluSrcImm = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        branch    = 1'b0;
        branchNe  = 1'b0;
        jump      = 1'b0;
        wbSel     = WbAlu;
        aluOp     = Types::AluAdd;
        imm       = immI;
        case (opcode)
            OpReg: begin
                regWrite = 1'b1;
                case (funct3)
                    3'b000:  aluOp = subFlag ? Types::AluSub : Types::AluAdd;
                    3'b100:  aluOp = Types::AluXor;
                    3'b110:  aluOp = Types::AluOr;
                    3'b111:  aluOp = Types::AluAnd;
                    default: regWrite = 1'b0;
                endcase
            end
            OpImm: begin
                regWrite  = funct3 == 3'b000; // ADDI only
                aluSrcImm = 1'b1;
            end
            OpLui: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = Types::AluPassB;
                imm       = immU;
            end
            OpLoad: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                memRead   = 1'b1;
                wbSel     = WbMem;
            end
            OpStore: begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
                imm       = immS;
            end
            OpBranch: begin
                branch   = funct3[2:1] == 2'b00;  // BEQ, BNE
                branchNe = funct3[0];
                aluOp    = Types::AluSub;
                imm      = immB;
            end
            OpJal: begin
                regWrite = 1'b1;
                jump     = 1'b1;
                wbSel    = WbLink;
                imm      = immJ;
            end
            default: ;
        endcase
    end

    // ----------------------------------------------------------------------
    // Execute, memory, write-back
    // ----------------------------------------------------------------------

    RegisterFile regFile (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_rs1     (rs1),
        .i_rs2     (rs2),
        .o_rs1Data (rs1Data),
        .o_rs2Data (rs2Data),
        .i_we      (regWrite && retire),  // Stall holds registers
        .i_rd      (rd),
        .i_wdata   (wbData));

    assign aluB = aluSrcImm ? imm : rs2Data;

    Alu alu (
        .i_op     (aluOp),
        .i_a      (rs1Data),
        .i_b      (aluB),
        .o_result (aluResult),
        .o_zero   (aluZero));

    // Data request straight from the current instruction
    assign dataBus.addr  = aluResult;
    assign dataBus.wdata = rs2Data;
    assign dataBus.re    = memRead && haveInst && !i_reset;
    assign dataBus.we    = memWrite && haveInst && !i_reset;

    assign pcPlus4     = pc + 32'd4;
    assign branchTaken = branch && (aluZero != branchNe);
    assign pcNext      = (jump || branchTaken) ? pc + imm : pcPlus4;

    always_comb begin
        case (wbSel)
            WbMem:   wbData = dataBus.rdata;
            WbLink:  wbData = pcPlus4;        // JAL link
            default: wbData = aluResult;
        endcase
    end

    // PC and held instruction
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            pc            <= `RV_RESET_PC;
            instHeldValid <= 1'b0;
        end
        else if (retire) begin
            pc            <= pcNext;
            instHeldValid <= 1'b0;
        end
        else if (haveInst)
            instHeldValid <= 1'b1;            // Waiting on data bus
    end

    always_ff @(posedge i_clock)
        if (!instHeldValid)
            instHeld <= instBus.inst;

endmodule

// File: verilog/InstL1Cache.sv
/*
 * Direct-mapped read-only L1 instruction cache. Hits answer in the same
 * cycle; a miss holds busy and fills the whole line word by word.
 */

`include "Processor_settings.svh"

module InstL1Cache (
    input  logic       i_clock, // Clock
    input  logic       i_reset, // Reset
    InstCoreBus.slave  coreBus, // Core side
    InstCoreBus.master bus);    // External side

    localparam int Lines      = `RV_ICACHE_LINES;
    localparam int LineWords  = `RV_ICACHE_LINE_WORDS;
    localparam int OffsetBits = $clog2(LineWords);
    localparam int IndexBits  = $clog2(Lines);
    localparam int TagBits    = 32 - IndexBits - OffsetBits - 2;

    // Arrays
    logic [TagBits-1:0] tagArray  [Lines];
    logic               validArray[Lines];
    Types::Word         dataArray [Lines][LineWords];

    Types::CacheState   state;
    logic [OffsetBits-1:0] wordCnt;   // Fill word counter
    logic [TagBits-1:0]    fillTag;   // Line being filled
    logic [IndexBits-1:0]  fillIndex;

    // Address fields of the core request
    logic [TagBits-1:0]    reqTag;
    logic [IndexBits-1:0]  reqIndex;
    logic [OffsetBits-1:0] reqWord;
    logic                  hit;
    logic                  lastWord;

    assign reqTag   = coreBus.addr[31 -: TagBits];
    assign reqIndex = coreBus.addr[OffsetBits+2 +: IndexBits];
    assign reqWord  = coreBus.addr[2 +: OffsetBits];
    assign hit      = validArray[reqIndex] && (tagArray[reqIndex] == reqTag);
    assign lastWord = wordCnt == OffsetBits'(LineWords - 1);

    // Core side answers straight from the data array
    assign coreBus.inst = dataArray[reqIndex][reqWord];
    assign coreBus.busy = coreBus.re && ((state == Types::Fill) || !hit);

    // External side only reads while filling
    assign bus.re   = state == Types::Fill;
    assign bus.addr = {fillTag, fillIndex, wordCnt, 2'b00}; // Line aligned walk

    // ----------------------------------------------------------------------
    // Control FSM
    // ----------------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state   <= Types::Lookup;
            wordCnt <= '0;
            for (int i = 0; i < Lines; i++)
                validArray[i] <= 1'b0;                // Everything invalid
        end
        else begin
            case (state)
                Types::Lookup:
                    if (coreBus.re && !hit) begin
                        state               <= Types::Fill;
                        wordCnt             <= '0;
                        validArray[reqIndex] <= 1'b0; // Line is overwritten
                    end
                Types::Fill:
                    if (!bus.busy) begin              // Word arrived
                        wordCnt <= wordCnt + 1'b1;
                        if (lastWord) begin
                            validArray[fillIndex] <= 1'b1;
                            state                 <= Types::Lookup;
                        end
                    end
                default: state <= Types::Lookup;
            endcase
        end
    end

    // Tags, line address and data words
    always_ff @(posedge i_clock) begin
        if (state == Types::Lookup) begin
            fillTag   <= reqTag;    // Latched for the whole fill
            fillIndex <= reqIndex;
        end
        else if (!bus.busy) begin
            dataArray[fillIndex][wordCnt] <= bus.inst;
            if (lastWord)
                tagArray[fillIndex] <= fillTag;
        end
    end

endmodule

// File: verilog/Processor.sv
/*
 * Processor subsystem top level. Single-cycle core with an optional L1
 * instruction cache; both buses leave as plain ports.
 */

`include "Processor_settings.svh"

module Processor (
    input  logic       i_clock,     // Clock
    input  logic       i_reset,     // Reset
    output Types::Addr o_instAddr,  // Instruction bus
    output logic       o_instRe,
    input  Types::Inst i_inst,
    input  logic       i_instBusy,
    output Types::Addr o_dataAddr,  // Data bus
    output logic       o_dataWe,
    output logic       o_dataRe,
    output Types::Word o_dataWdata,
    input  Types::Word i_dataRdata,
    input  logic       i_dataBusy);

    InstCoreBus coreInstBus(); // Core instruction side
    DataCoreBus coreDataBus(); // Core data side

    // ----------------------------------------------------------------------
    // L1 instruction cache or wires
    // ----------------------------------------------------------------------

    generate
        if (`RV_ICACHE_ON == 1) begin : gCache
            InstCoreBus extInstBus();      // Cache to outside

            InstL1Cache instL1Cache (
                .i_clock (i_clock),
                .i_reset (i_reset),
                .coreBus (coreInstBus),
                .bus     (extInstBus));

            assign o_instAddr      = extInstBus.addr;
            assign o_instRe        = extInstBus.re;
            assign extInstBus.inst = i_inst;
            assign extInstBus.busy = i_instBusy;
        end
        else begin : gNoCache
            assign o_instAddr       = coreInstBus.addr;
            assign o_instRe         = coreInstBus.re;
            assign coreInstBus.inst = i_inst;
            assign coreInstBus.busy = i_instBusy;
        end
    endgenerate

    // Data bus goes straight out
    assign o_dataAddr        = coreDataBus.addr;
    assign o_dataWe          = coreDataBus.we;
    assign o_dataRe          = coreDataBus.re;
    assign o_dataWdata       = coreDataBus.wdata;
    assign coreDataBus.rdata = i_dataRdata;
    assign coreDataBus.busy  = i_dataBusy;

    CoreSC core (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .instBus (coreInstBus),
        .dataBus (coreDataBus));

endmodule

// File: verilog/Processor_settings.svh
/*
 * Build settings for the processor subsystem. Included by every RTL file
 * that needs the cache switch, the cache geometry or the reset PC.
 */

`ifndef PROCESSOR_SETTINGS_SVH
`define PROCESSOR_SETTINGS_SVH

// ------------------------------------------------------------------------
// Instruction cache
// ------------------------------------------------------------------------

`define RV_ICACHE_ON         1        // 1 = L1 instruction cache, 0 = wires
`define RV_ICACHE_LINES      8        // Line count, power of two
`define RV_ICACHE_LINE_WORDS 4        // Words per line, power of two

// First fetch address after reset
`define RV_RESET_PC          32'h0000_0000

`endif

// File: verilog/RegisterFile.sv
/*
 * Integer register file, 32 x 32 bits. Two asynchronous read ports and
 * one synchronous write port; x0 always reads zero.
 */

module RegisterFile (
    input  logic           i_clock,   // Clock
    input  logic           i_reset,   // Reset
    input  Types::RegIndex i_rs1,     // Read port 1 index
    input  Types::RegIndex i_rs2,     // Read port 2 index
    output Types::Word     o_rs1Data, // Read port 1 data
    output Types::Word     o_rs2Data, // Read port 2 data
    input  logic           i_we,      // Write enable
    input  Types::RegIndex i_rd,      // Write index
    input  Types::Word     i_wdata);  // Write data

    Types::Word regs[32];

    // Reads are combinational
    assign o_rs1Data = regs[i_rs1];
    assign o_rs2Data = regs[i_rs2];

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (i_we && (i_rd != '0))   // x0 stays zero
            regs[i_rd] <= i_wdata;
    end

endmodule

// File: verilog/Types.sv
/*
 * Shared types of the processor subsystem. All files refer to them with
 * scoped names, Types::Word and so on.
 */

package Types;

    typedef logic [31:0] Word;     // Data and register value
    typedef logic [31:0] Inst;     // Instruction word
    typedef logic [31:0] Addr;     // Byte address, both buses
    typedef logic [4:0]  RegIndex; // Register number

    // ALU operation selector
    typedef logic [2:0]  AluOp;

    localparam AluOp AluAdd   = 3'd0;
    localparam AluOp AluSub   = 3'd1;
    localparam AluOp AluAnd   = 3'd2;
    localparam AluOp AluOr    = 3'd3;
    localparam AluOp AluXor   = 3'd4;
    localparam AluOp AluPassB = 3'd5; // LUI passes the immediate

    // Instruction cache FSM
    typedef enum logic {
        Lookup, // Idle or answering hits
        Fill    // Refilling a line from the external bus
    } CacheState;

endpackage
